// File: hdl/mulPkg.sv
// shared widths, depths and encodings for the multiplier property tester
// imported by every RTL block that needs a size or a test-kind code

package mulPkg;

    // operand and product widths
    localparam int OP_WIDTH = 8;
    localparam int PROD_WIDTH = 2 * OP_WIDTH;

    // two lanes per pair, lane A at 2p and lane B at 2p+1
    localparam int NUM_PAIRS = 2;
    localparam int NUM_LANES = 2 * NUM_PAIRS;

    // request queue depth, also the sender's credits after reset
    localparam int REQ_DEPTH = 4;
    // result queue depth, also the dispatcher's internal credits
    localparam int RES_DEPTH = 4;

    localparam int REQ_PTR_WIDTH = $clog2(REQ_DEPTH);
    localparam int RES_PTR_WIDTH = $clog2(RES_DEPTH);

    // one load cycle plus one cycle per multiplier bit
    localparam int MUL_LATENCY = OP_WIDTH + 1;

    // test kinds
    localparam logic KIND_COMMUT = 1'b0;
    localparam logic KIND_TIMING = 1'b1;

    // wide enough to count up to the larger queue depth
    localparam int CREDIT_WIDTH =
        $clog2(((REQ_DEPTH > RES_DEPTH) ? REQ_DEPTH : RES_DEPTH) + 1);

endpackage

// File: hdl/seqMultiplier.sv
// sequential shift-and-add multiplier lane with operand-independent latency
// pulse start with both operands, product is ready with productDone

`timescale 1ns/100ps

module seqMultiplier #(
    parameter int WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [WIDTH-1:0]       multiplier,
    input  logic [WIDTH-1:0]       multiplicand,
    output logic [2*WIDTH-1:0]     product,
    output logic                   productDone
);

    // working copies of the operands
    logic [WIDTH-1:0]         mplierReg;
    logic [2*WIDTH-1:0]       mcandReg;
    logic [2*WIDTH-1:0]       acc;
    logic [2*WIDTH-1:0]       nextAcc;
    logic [$clog2(WIDTH+1)-1:0] stepCount;
    logic                     busy;
    logic                     lastStep;

    // add the shifted multiplicand only for a set multiplier bit
    assign nextAcc = mplierReg[0] ? (acc + mcandReg) : acc;

    // the counter alone decides when the run ends
    assign lastStep = (stepCount == ($clog2(WIDTH+1))'(WIDTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            stepCount <= '0;
            productDone <= 1'b0;
        end else begin
            productDone <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                stepCount <= '0;
            end else if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (lastStep) begin
                    busy <= 1'b0;
                    productDone <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mplierReg <= multiplier;
            mcandReg <= {{WIDTH{1'b0}}, multiplicand};
            acc <= '0;
        end else if (busy) begin
            mplierReg <= mplierReg >> 1;
            mcandReg <= mcandReg << 1;
            acc <= nextAcc;
            // stored together with the done pulse, held until the next run ends
            if (lastStep) begin
                product <= nextAcc;
            end
        end
    end

endmodule

// File: hdl/testDispatcher.sv
// queues incoming test requests and launches them onto free lane pairs
// returns one input credit per popped request, spends one result credit per launch

`timescale 1ns/100ps

module testDispatcher (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        reqValid,
    input  logic                                        reqKind,
    input  logic [mulPkg::OP_WIDTH-1:0]                 reqX,
    input  logic [mulPkg::OP_WIDTH-1:0]                 reqY,
    input  logic [mulPkg::OP_WIDTH-1:0]                 reqK,
    output logic                                        reqCredit,
    input  logic                                        resFree,
    input  logic [mulPkg::NUM_PAIRS-1:0]                pairDone,
    output logic [mulPkg::NUM_LANES-1:0]                laneStart,
    output logic [mulPkg::NUM_LANES*mulPkg::OP_WIDTH-1:0] laneMultiplier,
    output logic [mulPkg::NUM_LANES*mulPkg::OP_WIDTH-1:0] laneMultiplicand,
    output logic [mulPkg::NUM_PAIRS-1:0]                pairLaunch,
    output logic                                        pairKind
);

    import mulPkg::*;

    // request storage
    logic                qKind [REQ_DEPTH];
    logic [OP_WIDTH-1:0] qX [REQ_DEPTH];
    logic [OP_WIDTH-1:0] qY [REQ_DEPTH];
    logic [OP_WIDTH-1:0] qK [REQ_DEPTH];

    logic [REQ_PTR_WIDTH-1:0] wrPtr;
    logic [REQ_PTR_WIDTH-1:0] rdPtr;
    logic [CREDIT_WIDTH-1:0]  reqCount;
    logic [CREDIT_WIDTH-1:0]  resCredits;
    logic [NUM_PAIRS-1:0]     pairBusy;
    logic [NUM_PAIRS-1:0]     pairSel;
    logic                     pop;

    // operands for lane A and lane B of the launched pair
    logic [OP_WIDTH-1:0] aMplier;
    logic [OP_WIDTH-1:0] aMcand;
    logic [OP_WIDTH-1:0] bMplier;
    logic [OP_WIDTH-1:0] bMcand;

    // lowest-numbered idle pair wins
    always_comb begin
        pairSel = '0;
        for (int p = NUM_PAIRS - 1; p >= 0; p--) begin
            if (!pairBusy[p]) begin
                pairSel = '0;
                pairSel[p] = 1'b1;
            end
        end
    end

    assign pop = (reqCount != '0) && (resCredits != '0) && (|pairSel);
    assign reqCredit = pop;
    assign pairLaunch = pop ? pairSel : '0;
    assign pairKind = qKind[rdPtr];

    // commutative runs x*y and y*x while timing runs x*k and y*k
    always_comb begin
        aMplier = qX[rdPtr];
        bMplier = qY[rdPtr];
        if (qKind[rdPtr] == KIND_COMMUT) begin
            aMcand = qY[rdPtr];
            bMcand = qX[rdPtr];
        end else begin
            aMcand = qK[rdPtr];
            bMcand = qK[rdPtr];
        end
    end

    // every pair sees the head operands, only the launched one starts
    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            laneStart[2*p] = pairLaunch[p];
            laneStart[2*p+1] = pairLaunch[p];
            laneMultiplier[2*p*OP_WIDTH +: OP_WIDTH] = aMplier;
            laneMultiplicand[2*p*OP_WIDTH +: OP_WIDTH] = aMcand;
            laneMultiplier[(2*p+1)*OP_WIDTH +: OP_WIDTH] = bMplier;
            laneMultiplicand[(2*p+1)*OP_WIDTH +: OP_WIDTH] = bMcand;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            qKind[wrPtr] <= reqKind;
            qX[wrPtr] <= reqX;
            qY[wrPtr] <= reqY;
            qK[wrPtr] <= reqK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            reqCount <= '0;
            resCredits <= CREDIT_WIDTH'(RES_DEPTH);
            pairBusy <= '0;
        end else begin
            if (reqValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (reqValid && !pop) begin
                reqCount <= reqCount + 1'b1;
            end else if (!reqValid && pop) begin
                reqCount <= reqCount - 1'b1;
            end
            // one result slot reserved per launch
            if (pop && !resFree) begin
                resCredits <= resCredits - 1'b1;
            end else if (!pop && resFree) begin
                resCredits <= resCredits + 1'b1;
            end
            pairBusy <= (pairBusy & ~pairDone) | pairLaunch;
        end
    end

endmodule

// File: hdl/verdictCollector.sv
// turns finished lane pairs into pass/fail verdicts and queues them in order
// sends results under output credits and frees one internal credit per result

`timescale 1ns/100ps

module verdictCollector (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [mulPkg::NUM_PAIRS-1:0]                  pairLaunch,
    input  logic                                          pairKind,
    input  logic [mulPkg::NUM_LANES-1:0]                  laneDone,
    input  logic [mulPkg::NUM_LANES*mulPkg::PROD_WIDTH-1:0] laneProduct,
    output logic [mulPkg::NUM_PAIRS-1:0]                  pairDone,
    output logic                                          resFree,
    input  logic                                          resCredit,
    output logic                                          resValid,
    output logic                                          resKind,
    output logic [mulPkg::PROD_WIDTH-1:0]                 resProdA,
    output logic [mulPkg::PROD_WIDTH-1:0]                 resProdB,
    output logic                                          resPass
);

    import mulPkg::*;

    // per-pair tracking
    logic [NUM_PAIRS-1:0]  kindReg;
    logic [NUM_PAIRS-1:0]  doneAReg;
    logic [NUM_PAIRS-1:0]  doneBReg;
    logic [NUM_PAIRS-1:0]  complete;
    logic [NUM_PAIRS-1:0]  sameCycle;
    logic [NUM_PAIRS-1:0]  verdict;
    logic [PROD_WIDTH-1:0] prodA [NUM_PAIRS];
    logic [PROD_WIDTH-1:0] prodB [NUM_PAIRS];

    // result queue
    logic                  qKind [RES_DEPTH];
    logic [PROD_WIDTH-1:0] qProdA [RES_DEPTH];
    logic [PROD_WIDTH-1:0] qProdB [RES_DEPTH];
    logic                  qPass [RES_DEPTH];

    logic [RES_PTR_WIDTH-1:0] wrPtr;
    logic [RES_PTR_WIDTH-1:0] rdPtr;
    logic [RES_PTR_WIDTH-1:0] pushSlot [NUM_PAIRS];
    logic [CREDIT_WIDTH-1:0]  pushCount;
    logic [CREDIT_WIDTH-1:0]  resCount;
    logic [CREDIT_WIDTH-1:0]  outCredits;
    logic                     pop;

    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            // a pair completes in the cycle of its later done pulse
            complete[p] = (doneAReg[p] | laneDone[2*p]) & (doneBReg[p] | laneDone[2*p+1]);
            sameCycle[p] = laneDone[2*p] & laneDone[2*p+1];
            // lane products hold until the pair is restarted
            prodA[p] = laneProduct[2*p*PROD_WIDTH +: PROD_WIDTH];
            prodB[p] = laneProduct[(2*p+1)*PROD_WIDTH +: PROD_WIDTH];
            if (kindReg[p] == KIND_COMMUT) begin
                verdict[p] = (prodA[p] == prodB[p]);
            end else begin
                verdict[p] = sameCycle[p];
            end
        end
    end

    assign pairDone = complete;

    // queue slots for this cycle's completions, lower pair first
    always_comb begin
        pushCount = '0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            pushSlot[p] = wrPtr + RES_PTR_WIDTH'(pushCount);
            pushCount = pushCount + CREDIT_WIDTH'(complete[p]);
        end
    end

    assign pop = (resCount != '0) && (outCredits != '0);
    assign resFree = pop;

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            if (pairLaunch[p]) begin
                kindReg[p] <= pairKind;
            end
            if (complete[p]) begin
                qKind[pushSlot[p]] <= kindReg[p];
                qProdA[pushSlot[p]] <= prodA[p];
                qProdB[pushSlot[p]] <= prodB[p];
                qPass[pushSlot[p]] <= verdict[p];
            end
        end
        if (pop) begin
            resKind <= qKind[rdPtr];
            resProdA <= qProdA[rdPtr];
            resProdB <= qProdB[rdPtr];
            resPass <= qPass[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            doneAReg <= '0;
            doneBReg <= '0;
            wrPtr <= '0;
            rdPtr <= '0;
            resCount <= '0;
            outCredits <= CREDIT_WIDTH'(RES_DEPTH);
            resValid <= 1'b0;
        end else begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                if (complete[p] || pairLaunch[p]) begin
                    doneAReg[p] <= 1'b0;
                    doneBReg[p] <= 1'b0;
                end else begin
                    if (laneDone[2*p]) begin
                        doneAReg[p] <= 1'b1;
                    end
                    if (laneDone[2*p+1]) begin
                        doneBReg[p] <= 1'b1;
                    end
                end
            end
            wrPtr <= wrPtr + RES_PTR_WIDTH'(pushCount);
            rdPtr <= rdPtr + RES_PTR_WIDTH'(pop);
            resCount <= resCount + pushCount - CREDIT_WIDTH'(pop);
            outCredits <= outCredits + CREDIT_WIDTH'(resCredit) - CREDIT_WIDTH'(pop);
            resValid <= pop;
        end
    end

endmodule

// File: hdl/multiplierTester.sv
// top level of the multiplier property tester
// requests in and verdicts out, both under credit-based flow control

`timescale 1ns/100ps

module multiplierTester (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          reqValid,
    input  logic                          reqKind,
    input  logic [mulPkg::OP_WIDTH-1:0]   reqX,
    input  logic [mulPkg::OP_WIDTH-1:0]   reqY,
    input  logic [mulPkg::OP_WIDTH-1:0]   reqK,
    output logic                          reqCredit,
    input  logic                          resCredit,
    output logic                          resValid,
    output logic                          resKind,
    output logic [mulPkg::PROD_WIDTH-1:0] resProdA,
    output logic [mulPkg::PROD_WIDTH-1:0] resProdB,
    output logic                          resPass
);

    import mulPkg::*;

    // lane vectors, lane i at bits [i*W +: W]
    logic [NUM_LANES-1:0]            laneStart;
    logic [NUM_LANES*OP_WIDTH-1:0]   laneMultiplier;
    logic [NUM_LANES*OP_WIDTH-1:0]   laneMultiplicand;
    logic [NUM_LANES*PROD_WIDTH-1:0] laneProduct;
    logic [NUM_LANES-1:0]            laneDone;

    logic [NUM_PAIRS-1:0] pairLaunch;
    logic [NUM_PAIRS-1:0] pairDone;
    logic                 pairKind;
    logic                 resFree;

    testDispatcher dispatcher (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqKind(reqKind),
        .reqX(reqX),
        .reqY(reqY),
        .reqK(reqK),
        .reqCredit(reqCredit),
        .resFree(resFree),
        .pairDone(pairDone),
        .laneStart(laneStart),
        .laneMultiplier(laneMultiplier),
        .laneMultiplicand(laneMultiplicand),
        .pairLaunch(pairLaunch),
        .pairKind(pairKind)
    );

    // identical lanes, pairs are formed by index only
    for (genvar i = 0; i < NUM_LANES; i++) begin : genLane
        seqMultiplier #(.WIDTH(OP_WIDTH)) lane (
            .clk(clk),
            .rst(rst),
            .start(laneStart[i]),
            .multiplier(laneMultiplier[i*OP_WIDTH +: OP_WIDTH]),
            .multiplicand(laneMultiplicand[i*OP_WIDTH +: OP_WIDTH]),
            .product(laneProduct[i*PROD_WIDTH +: PROD_WIDTH]),
            .productDone(laneDone[i])
        );
    end

    verdictCollector collector (
        .clk(clk),
        .rst(rst),
        .pairLaunch(pairLaunch),
        .pairKind(pairKind),
        .laneDone(laneDone),
        .laneProduct(laneProduct),
        .pairDone(pairDone),
        .resFree(resFree),
        .resCredit(resCredit),
        .resValid(resValid),
        .resKind(resKind),
        .resProdA(resProdA),
        .resProdB(resProdB),
        .resPass(resPass)
    );

endmodule

// File: tests/multiplierTester_chk.sv
// concurrent assertions on the credit handshakes and the lane latency
// bound into multiplierTester next to its lanes and credit ports

`timescale 1ns/100ps

module multiplierTester_chk (
    input logic                         clk,
    input logic                         rst,
    input logic                         reqValid,
    input logic                         reqCredit,
    input logic [mulPkg::NUM_LANES-1:0] laneStart,
    input logic [mulPkg::NUM_LANES-1:0] laneDone,
    input logic                         resValid,
    input logic                         resCredit
);

    import mulPkg::*;

    // credits held by the sender and by the DUT's output side
    logic [CREDIT_WIDTH-1:0] senderCredits;
    logic [CREDIT_WIDTH-1:0] outCredits;

    // set by any failing assertion and watched by the testbench
    logic failSeen = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            senderCredits <= CREDIT_WIDTH'(REQ_DEPTH);
            outCredits <= CREDIT_WIDTH'(RES_DEPTH);
        end else begin
            senderCredits <= senderCredits + CREDIT_WIDTH'(reqCredit) - CREDIT_WIDTH'(reqValid);
            outCredits <= outCredits + CREDIT_WIDTH'(resCredit) - CREDIT_WIDTH'(resValid);
        end
    end

    senderInCredit: assert property (@(posedge clk) disable iff (rst)
        reqValid |-> senderCredits != '0)
        else begin
            failSeen = 1'b1;
            $error("request sent while the sender held no credit");
        end

    resultInCredit: assert property (@(posedge clk) disable iff (rst)
        resValid |-> outCredits != '0)
        else begin
            failSeen = 1'b1;
            $error("result sent while no output credit was held");
        end

    for (genvar i = 0; i < NUM_LANES; i++) begin : genLaneChk
        doneAfterStart: assert property (@(posedge clk) disable iff (rst)
            laneStart[i] |-> ##MUL_LATENCY laneDone[i])
            else begin
                failSeen = 1'b1;
                $error("lane %0d missed its done pulse", i);
            end
        noEarlyDone: assert property (@(posedge clk) disable iff (rst)
            laneDone[i] |-> $past(laneStart[i], MUL_LATENCY))
            else begin
                failSeen = 1'b1;
                $error("lane %0d done without a start at fixed latency", i);
            end
    end

endmodule

bind multiplierTester multiplierTester_chk propertyChk (
    .clk(clk),
    .rst(rst),
    .reqValid(reqValid),
    .reqCredit(reqCredit),
    .laneStart(laneStart),
    .laneDone(laneDone),
    .resValid(resValid),
    .resCredit(resCredit)
);

// File: tests/multiplierTester_tb.sv
// testbench for the multiplier property tester
// sends a table of commutative and timing tests and checks each verdict in order

`timescale 1ns/100ps

module multiplierTester_tb;

    import mulPkg::*;

    localparam int NUM_ROWS = 16;
    // sink starts stalling after this many results
    localparam int STALL_FROM = 4;
    localparam int SEND_TIMEOUT = 1000;
    localparam int RESULT_TIMEOUT = 1000;

    typedef struct packed {
        logic                  kind;
        logic [OP_WIDTH-1:0]   x;
        logic [OP_WIDTH-1:0]   y;
        logic [OP_WIDTH-1:0]   k;
        logic [PROD_WIDTH-1:0] prodA;
        logic [PROD_WIDTH-1:0] prodB;
        logic                  pass;
    } stimRow;

    logic                  clk;
    logic                  rst;
    logic                  reqValid;
    logic                  reqKind;
    logic [OP_WIDTH-1:0]   reqX;
    logic [OP_WIDTH-1:0]   reqY;
    logic [OP_WIDTH-1:0]   reqK;
    logic                  reqCredit;
    logic                  resCredit;
    logic                  resValid;
    logic                  resKind;
    logic [PROD_WIDTH-1:0] resProdA;
    logic [PROD_WIDTH-1:0] resProdB;
    logic                  resPass;

    stimRow      rows [NUM_ROWS];
    logic        stallMode;
    logic [31:0] lfsrState;
    int          pending;
    int          stallLeft;
    int          maxPending;

    multiplierTester DUT (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqKind(reqKind),
        .reqX(reqX),
        .reqY(reqY),
        .reqK(reqK),
        .reqCredit(reqCredit),
        .resCredit(resCredit),
        .resValid(resValid),
        .resKind(resKind),
        .resProdA(resProdA),
        .resProdB(resProdB),
        .resPass(resPass)
    );

    always #4 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic abortRun();
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, what, got, expected);
            abortRun();
        end
    endtask

    // kind, x, y, k, expected product A, expected product B, expected pass
    task automatic loadTable();
        rows[0]  = '{KIND_COMMUT, 8'd0,   8'd37,  8'd0,   16'd0,     16'd0,     1'b1};
        rows[1]  = '{KIND_COMMUT, 8'd1,   8'd255, 8'd0,   16'd255,   16'd255,   1'b1};
        rows[2]  = '{KIND_COMMUT, 8'd255, 8'd255, 8'd0,   16'd65025, 16'd65025, 1'b1};
        rows[3]  = '{KIND_COMMUT, 8'd255, 8'd1,   8'd0,   16'd255,   16'd255,   1'b1};
        rows[4]  = '{KIND_COMMUT, 8'd12,  8'd34,  8'd0,   16'd408,   16'd408,   1'b1};
        rows[5]  = '{KIND_COMMUT, 8'd200, 8'd3,   8'd0,   16'd600,   16'd600,   1'b1};
        rows[6]  = '{KIND_COMMUT, 8'd128, 8'd2,   8'd0,   16'd256,   16'd256,   1'b1};
        rows[7]  = '{KIND_COMMUT, 8'd99,  8'd77,  8'd0,   16'd7623,  16'd7623,  1'b1};
        rows[8]  = '{KIND_COMMUT, 8'd1,   8'd1,   8'd0,   16'd1,     16'd1,     1'b1};
        rows[9]  = '{KIND_TIMING, 8'd3,   8'd250, 8'd7,   16'd21,    16'd1750,  1'b1};
        rows[10] = '{KIND_TIMING, 8'd0,   8'd255, 8'd255, 16'd0,     16'd65025, 1'b1};
        rows[11] = '{KIND_TIMING, 8'd170, 8'd85,  8'd13,  16'd2210,  16'd1105,  1'b1};
        rows[12] = '{KIND_TIMING, 8'd1,   8'd128, 8'd200, 16'd200,   16'd25600, 1'b1};
        rows[13] = '{KIND_TIMING, 8'd17,  8'd240, 8'd255, 16'd4335,  16'd61200, 1'b1};
        rows[14] = '{KIND_COMMUT, 8'd46,  8'd91,  8'd0,   16'd4186,  16'd4186,  1'b1};
        rows[15] = '{KIND_TIMING, 8'd64,  8'd5,   8'd64,  16'd4096,  16'd320,   1'b1};
    endtask

    // sends one row per cycle while a credit is held
    task automatic sendAll();
        int row;
        int credits;
        int idle;
        row = 0;
        credits = REQ_DEPTH;
        idle = 0;
        while (row < NUM_ROWS) begin
            @(posedge clk);
            if (reqCredit) begin
                credits++;
            end
            checkValue("sender credits above queue depth", credits > REQ_DEPTH, 0);
            if (credits > 0) begin
                reqValid <= 1'b1;
                reqKind <= rows[row].kind;
                reqX <= rows[row].x;
                reqY <= rows[row].y;
                reqK <= rows[row].k;
                credits--;
                row++;
                idle = 0;
            end else begin
                reqValid <= 1'b0;
                idle++;
                if (idle > SEND_TIMEOUT) begin
                    $display("timeout: no input credit came back for %0d cycles", idle);
                    abortRun();
                end
            end
        end
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic receiveAll();
        int waited;
        for (int r = 0; r < NUM_ROWS; r++) begin
            waited = 0;
            @(posedge clk);
            while (!resValid) begin
                if (waited == RESULT_TIMEOUT) begin
                    $display("timeout: result for row %0d never arrived", r);
                    abortRun();
                end
                waited++;
                @(posedge clk);
            end
            checkValue($sformatf("row %0d kind", r), resKind, rows[r].kind);
            checkValue($sformatf("row %0d product A", r), resProdA, rows[r].prodA);
            checkValue($sformatf("row %0d product B", r), resProdB, rows[r].prodB);
            checkValue($sformatf("row %0d pass", r), resPass, rows[r].pass);
            if (r + 1 == STALL_FROM) begin
                stallMode <= 1'b1;
            end
        end
        // nothing duplicated after the last row
        repeat (3 * MUL_LATENCY) begin
            @(posedge clk);
            checkValue("extra result after last row", resValid, 0);
        end
    endtask

    // sink returns one credit per result with long LFSR stalls once stallMode is set
    always @(posedge clk) begin
        if (rst) begin
            pending = 0;
            stallLeft = 0;
            resCredit <= 1'b0;
        end else begin
            resCredit <= 1'b0;
            if (resValid) begin
                pending++;
            end
            if (pending > maxPending) begin
                maxPending = pending;
            end
            if (pending > 0) begin
                if (stallLeft > 0) begin
                    stallLeft--;
                end else begin
                    resCredit <= 1'b1;
                    pending--;
                    if (stallMode) begin
                        stallLeft = 16;
                        for (int b = 0; b < 4; b++) begin
                            lfsrState = lfsrNext(lfsrState);
                            stallLeft = stallLeft + (int'(lfsrState[0]) << b);
                        end
                    end
                end
            end
        end
    end

    // a failing bound assertion ends the run at the next edge
    always @(posedge clk) begin
        if (DUT.propertyChk.failSeen) begin
            $display("a bound assertion on the DUT failed");
            abortRun();
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        reqValid = 1'b0;
        reqKind = 1'b0;
        reqX = '0;
        reqY = '0;
        reqK = '0;
        resCredit = 1'b0;
        stallMode = 1'b0;
        lfsrState = 32'h3f35;
        maxPending = 0;
        loadTable();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // quiet until the first request
        repeat (8) begin
            @(posedge clk);
            checkValue("reqCredit after reset", reqCredit, 0);
            checkValue("resValid after reset", resValid, 0);
        end
        fork
            sendAll();
            receiveAll();
        join
        // stalls must have used up every output credit at some point
        checkValue("peak results held by sink", maxPending, RES_DEPTH);
        if (DUT.propertyChk.failSeen) begin
            $display("a bound assertion on the DUT failed");
            abortRun();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: src.f
hdl/mulPkg.sv
hdl/seqMultiplier.sv
hdl/testDispatcher.sv
hdl/verdictCollector.sv
hdl/multiplierTester.sv
tests/multiplierTester_chk.sv
tests/multiplierTester_tb.sv

// File: Bender.yml
package:
  name: multiplier_tester

sources:
  - files:
      - hdl/mulPkg.sv
      - hdl/seqMultiplier.sv
      - hdl/testDispatcher.sv
      - hdl/verdictCollector.sv
      - hdl/multiplierTester.sv
  - target: test
    files:
      - tests/multiplierTester_chk.sv
      - tests/multiplierTester_tb.sv
